/* common/bk_pkg.sv */
`default_nettype none

package bk_pkg;

	//////////////////////////////////////////////////
	// Widths

	// Console byte and host buffer word
	typedef logic [7:0]  bk_byte_t;
	typedef logic [15:0] bk_word_t;

	// Word k of the store holds bytes 2k and 2k+1
	typedef logic [10:0] bk_byte_addr_t;
	typedef logic [9:0]  bk_word_addr_t;

	// Host side indices
	typedef logic [7:0]  bk_buff_addr_t;
	typedef logic [1:0]  bk_sector_t;
	typedef logic [31:0] bk_lba_t;

	//////////////////////////////////////////////////
	// Save file layout

	localparam int BK_RAM_BYTES        = 2048;
	localparam int BK_SECTORS          = 4;
	localparam int BK_WORDS_PER_SECTOR = 256;
	localparam int BK_FORMAT_WORDS     = 4;

	// Default header is "HUBM" then the size word pair
	localparam bk_word_t BK_HEADER_0 = 16'h5548;
	localparam bk_word_t BK_HEADER_1 = 16'h4D42;
	localparam bk_word_t BK_HEADER_2 = 16'h8800;
	localparam bk_word_t BK_HEADER_3 = 16'h8010;

	//////////////////////////////////////////////////
	// Bundles

	typedef struct packed {
		bk_byte_addr_t addr;
		bk_byte_t      wdata;
		logic          we;
	} bk_console_t;

	typedef struct packed {
		logic    rd;
		logic    wr;
		bk_lba_t lba;
	} bk_host_req_t;

	typedef struct packed {
		logic          ack;
		bk_buff_addr_t buff_addr;
		bk_word_t      buff_dout;
		logic          buff_wr;
	} bk_host_buf_t;

	// One word write into the store
	typedef struct packed {
		bk_word_addr_t addr;
		bk_word_t      data;
		logic          we;
	} bk_word_wr_t;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_XFER
	} bk_state_t;

endpackage

`default_nettype wire

/* src/bk_sector_counter.sv */
`default_nettype none

module bk_sector_counter (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                clear,
	input  wire                step,
	output bk_pkg::bk_sector_t sector,
	output logic               last
);

	// Index of the final sector of a transfer
	localparam bk_pkg::bk_sector_t LAST_SECTOR = bk_pkg::bk_sector_t'(bk_pkg::BK_SECTORS - 1);

	bk_pkg::bk_sector_t count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (step) begin
			// Sequencer never steps past the last sector
			if (count != LAST_SECTOR)
				count <= count + 1'b1;
		end
	end

	assign sector = count;
	assign last   = (count == LAST_SECTOR);

endmodule

`default_nettype wire

/* src/bk_sequencer.sv */
`default_nettype none

module bk_sequencer (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  load,
	input  wire                  save,
	input  wire                  img_mounted,
	input  wire                  img_readonly,
	input  wire                  console_we,
	input  wire                  ack,
	input  wire                  last,
	output bk_pkg::bk_host_req_t host_req,
	input  wire bk_pkg::bk_sector_t sector,
	output logic                 cnt_clear,
	output logic                 cnt_step,
	output logic                 busy,
	output logic                 loading,
	output logic                 pending
);

	bk_pkg::bk_state_t state;
	logic              enabled;
	logic              load_d;
	logic              save_d;
	logic              ack_d;
	logic              req_rd;
	logic              req_wr;
	logic              load_rise;
	logic              save_rise;
	logic              ack_rise;
	logic              ack_fall;
	logic              start;

	assign load_rise = load & ~load_d;
	assign save_rise = save & ~save_d;
	assign ack_rise  = ack & ~ack_d;
	assign ack_fall  = ~ack & ack_d;

	// Only accepted from idle with a writable image
	assign start     = (state == bk_pkg::BK_IDLE) && enabled && (load_rise || save_rise);
	assign cnt_clear = start;
	assign cnt_step  = (state == bk_pkg::BK_XFER) && ack_fall && !last;
	assign busy      = (state != bk_pkg::BK_IDLE);

	assign host_req = '{rd: req_rd, wr: req_wr, lba: bk_pkg::bk_lba_t'(sector)};

	//////////////////////////////////////////////////
	// Edge history and status flags

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_d  <= 1'b0;
			save_d  <= 1'b0;
			ack_d   <= 1'b0;
			enabled <= 1'b0;
			pending <= 1'b0;
		end else begin
			load_d <= load;
			save_d <= save;
			ack_d  <= ack;

			// A read-only mount disables saving again
			if (img_mounted)
				enabled <= ~img_readonly;

			if (start)
				pending <= 1'b0;
			else if (console_we && enabled)
				pending <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Transfer FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= bk_pkg::BK_IDLE;
			req_rd  <= 1'b0;
			req_wr  <= 1'b0;
			loading <= 1'b0;
		end else begin
			case (state)
				bk_pkg::BK_IDLE: begin
					if (start) begin
						// Load wins over a save on the same cycle
						loading <= load_rise;
						req_rd  <= load_rise;
						req_wr  <= ~load_rise;
						state   <= bk_pkg::BK_REQ;
					end
				end
				bk_pkg::BK_REQ: begin
					// Host took the request
					if (ack_rise) begin
						req_rd <= 1'b0;
						req_wr <= 1'b0;
						state  <= bk_pkg::BK_XFER;
					end
				end
				bk_pkg::BK_XFER: begin
					if (ack_fall) begin
						if (last) begin
							loading <= 1'b0;
							state   <= bk_pkg::BK_IDLE;
						end else begin
							req_rd <= loading;
							req_wr <= ~loading;
							state  <= bk_pkg::BK_REQ;
						end
					end
				end
				default: state <= bk_pkg::BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* bk_ram/bk_ram.sv */
`default_nettype none

module bk_ram (
	input  wire                  clk_sys,
	input  wire bk_pkg::bk_console_t console,
	output bk_pkg::bk_byte_t     rdata,
	input  wire bk_pkg::bk_word_wr_t host_wr,
	input  wire bk_pkg::bk_word_wr_t fmt_wr,
	input  wire                  fmt_busy,
	input  wire bk_pkg::bk_word_addr_t word_rd_addr,
	output bk_pkg::bk_word_t     word_rdata
);

	bk_pkg::bk_byte_t    mem [0:bk_pkg::BK_RAM_BYTES-1];
	bk_pkg::bk_word_wr_t word_wr;
	bk_pkg::bk_byte_addr_t wr_lo;
	bk_pkg::bk_byte_addr_t wr_hi;
	bk_pkg::bk_byte_addr_t rd_lo;
	bk_pkg::bk_byte_addr_t rd_hi;

	// Format writer owns the word port while it runs
	assign word_wr = fmt_busy ? fmt_wr : host_wr;

	// Low half at the even byte
	assign wr_lo = {word_wr.addr, 1'b0};
	assign wr_hi = {word_wr.addr, 1'b1};
	assign rd_lo = {word_rd_addr, 1'b0};
	assign rd_hi = {word_rd_addr, 1'b1};

	//////////////////////////////////////////////////
	// Writes from both sides

	always_ff @(posedge clk_sys) begin
		if (console.we)
			mem[console.addr] <= console.wdata;

		// Word side lands last on a collision
		if (word_wr.we) begin
			mem[wr_lo] <= word_wr.data[7:0];
			mem[wr_hi] <= word_wr.data[15:8];
		end
	end

	//////////////////////////////////////////////////
	// Registered reads

	always_ff @(posedge clk_sys) begin
		rdata <= mem[console.addr];
	end

	always_ff @(posedge clk_sys) begin
		word_rdata <= {mem[rd_hi], mem[rd_lo]};
	end

endmodule

`default_nettype wire

/* bk_ram/bk_format_writer.sv */
`default_nettype none

module bk_format_writer (
	input  wire                 clk_sys,
	input  wire                 reset,
	input  wire                 format,
	output bk_pkg::bk_word_wr_t fmt_wr,
	output logic                busy
);

	localparam int IDX_W = $clog2(bk_pkg::BK_FORMAT_WORDS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(bk_pkg::BK_FORMAT_WORDS - 1);

	logic             format_d;
	logic [IDX_W-1:0] idx;
	bk_pkg::bk_word_t header;

	// Header word for the current slot
	always_comb begin
		case (idx)
			2'd0:    header = bk_pkg::BK_HEADER_0;
			2'd1:    header = bk_pkg::BK_HEADER_1;
			2'd2:    header = bk_pkg::BK_HEADER_2;
			default: header = bk_pkg::BK_HEADER_3;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			format_d <= 1'b0;
			busy     <= 1'b0;
			idx      <= '0;
		end else begin
			format_d <= format;
			if (busy) begin
				idx <= idx + 1'b1;
				if (idx == IDX_LAST)
					busy <= 1'b0;
			end else if (format && !format_d) begin
				busy <= 1'b1;
				idx  <= '0;
			end
		end
	end

	// Header word k goes to store word k on busy cycle k
	assign fmt_wr = '{
		addr: bk_pkg::bk_word_addr_t'(idx),
		data: header,
		we:   busy
	};

endmodule

`default_nettype wire

/* src/bk_top.sv */
`default_nettype none

module bk_top (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire bk_pkg::bk_console_t console,
	output bk_pkg::bk_byte_t      rdata,
	input  wire                   load,
	input  wire                   save,
	input  wire                   format,
	input  wire                   img_mounted,
	input  wire                   img_readonly,
	output bk_pkg::bk_host_req_t  host_req,
	input  wire bk_pkg::bk_host_buf_t host_buf,
	output bk_pkg::bk_word_t      buff_din,
	output logic                  busy,
	output logic                  loading,
	output logic                  pending
);

	bk_pkg::bk_sector_t    sector;
	logic                  last;
	logic                  cnt_clear;
	logic                  cnt_step;
	bk_pkg::bk_word_addr_t host_addr;
	bk_pkg::bk_word_wr_t   host_wr;
	bk_pkg::bk_word_wr_t   fmt_wr;
	logic                  fmt_busy;

	// Sector index selects the quarter of the store
	assign host_addr = {sector, host_buf.buff_addr};

	// Host writes only land while a load is running
	assign host_wr = '{
		addr: host_addr,
		data: host_buf.buff_dout,
		we:   host_buf.buff_wr & host_buf.ack & loading
	};

	bk_sequencer seq0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.load         (load),
		.save         (save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.console_we   (console.we),
		.ack          (host_buf.ack),
		.last         (last),
		.host_req     (host_req),
		.sector       (sector),
		.cnt_clear    (cnt_clear),
		.cnt_step     (cnt_step),
		.busy         (busy),
		.loading      (loading),
		.pending      (pending)
	);

	bk_sector_counter cnt0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (cnt_clear),
		.step    (cnt_step),
		.sector  (sector),
		.last    (last)
	);

	bk_ram ram0 (
		.clk_sys      (clk_sys),
		.console      (console),
		.rdata        (rdata),
		.host_wr      (host_wr),
		.fmt_wr       (fmt_wr),
		.fmt_busy     (fmt_busy),
		.word_rd_addr (host_addr),
		.word_rdata   (buff_din)
	);

	bk_format_writer fmt0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.format  (format),
		.fmt_wr  (fmt_wr),
		.busy    (fmt_busy)
	);

endmodule

`default_nettype wire

/* tb/bk_tb.sv */
`default_nettype none

module bk_tb;

	logic                 clk_sys;
	logic                 reset;
	bk_pkg::bk_console_t  console;
	bk_pkg::bk_byte_t     rdata;
	logic                 load;
	logic                 save;
	logic                 format;
	logic                 img_mounted;
	logic                 img_readonly;
	bk_pkg::bk_host_req_t host_req;
	bk_pkg::bk_host_buf_t host_buf;
	bk_pkg::bk_word_t     buff_din;
	logic                 busy;
	logic                 loading;
	logic                 pending;

	// Header, sector bases, write pairs, expected save pairs
	logic [15:0]      golden [0:21];
	bk_pkg::bk_word_t image [0:1023];
	bk_pkg::bk_word_t saved [0:1023];
	integer           seed;

	bk_top dut0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.console      (console),
		.rdata        (rdata),
		.load         (load),
		.save         (save),
		.format       (format),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.host_req     (host_req),
		.host_buf     (host_buf),
		.buff_din     (buff_din),
		.busy         (busy),
		.loading      (loading),
		.pending      (pending)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Checking helpers

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("[ERROR] t=%0t timed out waiting for %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic compare_save_image();
		for (int k = 0; k < 1024; k++)
			check($sformatf("buff_din[%0d]", k), saved[k], image[k]);
	endtask

	//////////////////////////////////////////////////
	// Console side

	task automatic console_write(input bk_pkg::bk_byte_addr_t addr, input bk_pkg::bk_byte_t data);
		@(posedge clk_sys);
		console <= '{addr: addr, wdata: data, we: 1'b1};
		@(posedge clk_sys);
		console <= '{addr: addr, wdata: data, we: 1'b0};
		// Odd byte is the high half of the word
		if (addr[0])
			image[addr >> 1][15:8] = data;
		else
			image[addr >> 1][7:0] = data;
	endtask

	task automatic console_read(input bk_pkg::bk_byte_addr_t addr, output bk_pkg::bk_byte_t data);
		@(posedge clk_sys);
		console <= '{addr: addr, wdata: 8'h00, we: 1'b0};
		@(posedge clk_sys);
		@(negedge clk_sys);
		data = rdata;
	endtask

	//////////////////////////////////////////////////
	// Host block device

	task automatic serve_sector(input int s, input logic is_load, input int hold);
		int               t;
		int               delay;
		bk_pkg::bk_word_t w;
		t = 0;
		@(negedge clk_sys);
		while (!(host_req.rd || host_req.wr)) begin
			@(negedge clk_sys);
			t++;
			if (t > 100)
				report_timeout("a host sector request");
		end
		check("host_req.rd", host_req.rd, is_load);
		check("host_req.wr", host_req.wr, !is_load);
		check("host_req.lba", host_req.lba, s);
		delay = ($unsigned($random(seed)) % 8) + hold;
		// Request must hold while the host stalls
		repeat (delay) begin
			@(negedge clk_sys);
			check("host_req.rd", host_req.rd, is_load);
			check("host_req.wr", host_req.wr, !is_load);
			check("host_req.lba", host_req.lba, s);
			check("busy", busy, 1'b1);
			check("loading", loading, is_load);
		end
		for (int i = 0; i <= bk_pkg::BK_WORDS_PER_SECTOR; i++) begin
			@(posedge clk_sys);
			if (i < bk_pkg::BK_WORDS_PER_SECTOR) begin
				w = golden[4 + s] + 16'(i);
				host_buf <= '{ack: 1'b1, buff_addr: 8'(i), buff_dout: w, buff_wr: is_load};
				if (is_load)
					image[s * 256 + i] = w;
			end
			@(negedge clk_sys);
			// Request drops once ack is seen
			if (i == 1) begin
				check("host_req.rd", host_req.rd, 1'b0);
				check("host_req.wr", host_req.wr, 1'b0);
			end
			if (!is_load && i > 0)
				saved[s * 256 + i - 1] = buff_din;
		end
		@(posedge clk_sys);
		host_buf <= '{ack: 1'b0, buff_addr: 8'h00, buff_dout: 16'h0000, buff_wr: 1'b0};
	endtask

	task automatic run_transfer(input logic is_load, input int hold);
		int t;
		@(posedge clk_sys);
		load <= is_load;
		save <= !is_load;
		@(posedge clk_sys);
		load <= 1'b0;
		save <= 1'b0;
		@(negedge clk_sys);
		check("busy", busy, 1'b1);
		check("pending", pending, 1'b0);
		for (int s = 0; s < bk_pkg::BK_SECTORS; s++)
			serve_sector(s, is_load, (s == 1) ? hold : 0);
		t = 0;
		@(negedge clk_sys);
		while (busy) begin
			check("loading", loading, is_load);
			@(negedge clk_sys);
			t++;
			if (t > 100)
				report_timeout("busy to fall after the last sector");
		end
		check("loading", loading, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		bk_pkg::bk_byte_t b;
		seed = 75;
		$readmemh("tb/bk_golden.txt", golden);
		reset = 1'b1;
		console = '0;
		load = 1'b0;
		save = 1'b0;
		format = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		host_buf = '0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check("host_req.rd", host_req.rd, 1'b0);
		check("host_req.wr", host_req.wr, 1'b0);
		check("busy", busy, 1'b0);
		check("loading", loading, 1'b0);
		check("pending", pending, 1'b0);

		// No image mounted yet
		@(posedge clk_sys);
		save <= 1'b1;
		@(posedge clk_sys);
		save <= 1'b0;
		console_write(11'h010, 8'h77);
		repeat (2000) begin
			@(negedge clk_sys);
			check("host_req.rd", host_req.rd, 1'b0);
			check("host_req.wr", host_req.wr, 1'b0);
			check("busy", busy, 1'b0);
			check("pending", pending, 1'b0);
		end

		// Writable mount and a load of the golden image
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		run_transfer(1'b1, 0);
		for (int k = 0; k < 1024; k++) begin
			console_read(11'(2 * k), b);
			check($sformatf("rdata[%0d]", 2 * k), b, image[k][7:0]);
			console_read(11'(2 * k + 1), b);
			check($sformatf("rdata[%0d]", 2 * k + 1), b, image[k][15:8]);
		end

		// Format then save
		@(posedge clk_sys);
		format <= 1'b1;
		@(posedge clk_sys);
		format <= 1'b0;
		repeat (bk_pkg::BK_FORMAT_WORDS + 2) @(posedge clk_sys);
		for (int k = 0; k < bk_pkg::BK_FORMAT_WORDS; k++)
			image[k] = golden[k];
		run_transfer(1'b0, 0);
		compare_save_image();

		// Console writes before a save with a long host stall
		@(negedge clk_sys);
		check("pending", pending, 1'b0);
		for (int j = 0; j < 4; j++) begin
			console_write(golden[8 + 2 * j][10:0], golden[9 + 2 * j][7:0]);
			@(negedge clk_sys);
			check("pending", pending, 1'b1);
		end
		run_transfer(1'b0, 40);
		compare_save_image();
		for (int j = 0; j < 3; j++)
			check("buff_din", saved[golden[16 + 2 * j][9:0]], golden[17 + 2 * j]);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/bk_golden.txt */
// One hex value per entry. Entries 0-3 header words, 4-7 load bases for sectors 0-3
// (loaded word k of a sector is base + k), 8-15 console writes as byte address and
// byte, 16-21 expected save words as word address and word
// Format header
5548
4D42
8800
8010
// Load bases, sectors 0 to 3
1000
2000
3000
4000
// Console writes, byte address then byte
0100 00AB
0101 00CD
0402 0012
07FF 005A
// Expected save words, word address then word
0080 CDAB
0201 3012
03FF 5AFF

/* all.f */
common/bk_pkg.sv
src/bk_sector_counter.sv
src/bk_sequencer.sv
bk_ram/bk_ram.sv
bk_ram/bk_format_writer.sv
src/bk_top.sv
tb/bk_tb.sv
